//--- stereo_settings.svh
`ifndef STEREO_SETTINGS_SVH
`define STEREO_SETTINGS_SVH

// one component of a sample (re or im)
`define STEREO_PIXEL_W 8

// number of disparity taps searched
`define STEREO_NUM_DISP 11

// full width of one component product
`define STEREO_PROD_W (2 * `STEREO_PIXEL_W)

// sum of two products needs one extra bit
`define STEREO_SCORE_W (`STEREO_PROD_W + 1)

// index into the tap range
`define STEREO_DISP_W ($clog2(`STEREO_NUM_DISP))

`endif

//--- stereo_pkg.sv
`default_nettype none

`include "stereo_settings.svh"

package stereo_pkg;

   // one sample component
   typedef logic [`STEREO_PIXEL_W-1:0] pixel_t;

   // a sample is a re/im pair
   typedef struct packed {
      pixel_t re;
      pixel_t im;
   } sample_t;

   // index 0 holds the newest left sample
   typedef sample_t [`STEREO_NUM_DISP-1:0] tap_vec_t;

   // one component product
   typedef logic [`STEREO_PROD_W-1:0] prod_t;

   // correlation score, wide enough for re*re + im*im
   typedef logic [`STEREO_SCORE_W-1:0] score_t;

   // one score per disparity
   typedef score_t [`STEREO_NUM_DISP-1:0] score_vec_t;

   // disparity index
   typedef logic [`STEREO_DISP_W-1:0] disp_t;

   // winner of the max search
   typedef struct packed {
      disp_t  disp;
      score_t score;
   } disp_result_t;

endpackage

`default_nettype wire

//--- corr_delay_line.sv
`default_nettype none

`include "stereo_settings.svh"

module corr_delay_line (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                wen,
   input  wire stereo_pkg::sample_t left_in,
   input  wire stereo_pkg::sample_t right_in,
   output stereo_pkg::tap_vec_t     taps,
   output stereo_pkg::sample_t      right
);

   // left tap chain, one place per strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         taps <= '0;
      end
      else if (wen)
      begin
         taps[0] <= left_in;                        // newest sample enters tap 0
         for (int d = 1; d < `STEREO_NUM_DISP; d++)
         begin
            taps[d] <= taps[d-1];
         end
      end
   end

   // right sample is captured with the same strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         right <= '0;
      end
      else if (wen)
      begin
         right <= right_in;
      end
   end

endmodule

`default_nettype wire

//--- corr_cell.sv
`default_nettype none

`include "stereo_settings.svh"

module corr_cell (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire stereo_pkg::sample_t left,
   input  wire stereo_pkg::sample_t right,
   output stereo_pkg::score_t       score
);

   import stereo_pkg::*;

   prod_t prod_re;
   prod_t prod_im;

   // stage 1: component products
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         prod_re <= '0;
         prod_im <= '0;
      end
      else
      begin
         prod_re <= left.re * right.re;             // unsigned 8x8
         prod_im <= left.im * right.im;
      end
   end

   // stage 2: sum at full width, no overflow possible
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         score <= '0;
      end
      else
      begin
         score <= score_t'(prod_re) + score_t'(prod_im);
      end
   end

endmodule

`default_nettype wire

//--- corr_array.sv
`default_nettype none

`include "stereo_settings.svh"

module corr_array (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                sample_valid,
   input  wire stereo_pkg::sample_t left_in,
   input  wire stereo_pkg::sample_t right_in,
   output stereo_pkg::score_vec_t   scores,
   output logic                     score_valid
);

   import stereo_pkg::*;

   tap_vec_t   taps;
   sample_t    right_q;
   score_vec_t sums;                                // free-running cell outputs

   // strobe tracked alongside the data: taps, products, sums
   logic valid_tap;
   logic valid_prod;
   logic valid_sum;

   corr_delay_line u_delay_line (
      .clk      (clk),
      .reset    (reset),
      .wen      (sample_valid),
      .left_in  (left_in),
      .right_in (right_in),
      .taps     (taps),
      .right    (right_q)
   );

   // one cell per disparity, all sharing the right sample
   for (genvar d = 0; d < `STEREO_NUM_DISP; d++)
   begin : g_cell
      corr_cell u_cell (
         .clk   (clk),
         .reset (reset),
         .left  (taps[d]),
         .right (right_q),
         .score (sums[d])
      );
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         valid_tap  <= 1'b0;
         valid_prod <= 1'b0;
         valid_sum  <= 1'b0;
      end
      else
      begin
         valid_tap  <= sample_valid;
         valid_prod <= valid_tap;
         valid_sum  <= valid_prod;                  // sums now belong to that strobe
      end
   end

   // score bank holds between strobes
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         scores      <= '0;
         score_valid <= 1'b0;
      end
      else
      begin
         score_valid <= valid_sum;
         if (valid_sum)
         begin
            scores <= sums;
         end
      end
   end

endmodule

`default_nettype wire

//--- disparity_select.sv
`default_nettype none

`include "stereo_settings.svh"

module disparity_select (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire stereo_pkg::score_vec_t  scores,
   input  wire logic                    score_valid,
   output stereo_pkg::disp_result_t     best,
   output logic                         best_valid
);

   import stereo_pkg::*;

   disp_result_t cand;

   // linear max search; strict compare keeps the lowest index on ties
   always_comb
   begin
      cand.disp  = '0;
      cand.score = scores[0];
      for (int d = 1; d < `STEREO_NUM_DISP; d++)
      begin
         if (scores[d] > cand.score)
         begin
            cand.disp  = disp_t'(d);
            cand.score = scores[d];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         best       <= '0;
         best_valid <= 1'b0;
      end
      else
      begin
         best_valid <= score_valid;
         if (score_valid)
         begin
            best <= cand;                           // otherwise hold last result
         end
      end
   end

endmodule

`default_nettype wire

//--- stereo_corr_top.sv
`default_nettype none

module stereo_corr_top (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire logic                sample_valid,
   input  wire stereo_pkg::sample_t left_in,
   input  wire stereo_pkg::sample_t right_in,
   output stereo_pkg::score_vec_t   scores,
   output logic                     score_valid,
   output stereo_pkg::disp_result_t best,
   output logic                     best_valid
);

   // scores appear 3 cycles after the strobe
   corr_array u_corr_array (
      .clk          (clk),
      .reset        (reset),
      .sample_valid (sample_valid),
      .left_in      (left_in),
      .right_in     (right_in),
      .scores       (scores),
      .score_valid  (score_valid)
   );

   // best disparity one cycle later
   disparity_select u_disparity_select (
      .clk         (clk),
      .reset       (reset),
      .scores      (scores),
      .score_valid (score_valid),
      .best        (best),
      .best_valid  (best_valid)
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;                        // 10 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;                                 // released off the edge like other inputs
   end

endmodule

`default_nettype wire

//--- tb_stereo_corr.sv
`default_nettype none

`include "stereo_settings.svh"

module tb_stereo_corr;

   timeunit 1ns;
   timeprecision 100ps;

   import stereo_pkg::*;

   // strobes, idle gaps, drains and a margin, all in clock cycles
   localparam int max_cycles = 290 + 13 * 6 + 30 * 7 + 6 * 11 + 200;
   // points on a circle of radius 65, so only an exact match reaches 4225
   localparam int ring_re [10] = '{65, 63, 60, 56, 52, 39, 33, 25, 16, 0};

   logic         clk;
   logic         reset;
   logic         sample_valid;
   sample_t      left_in;
   sample_t      right_in;
   score_vec_t   scores;
   logic         score_valid;
   disp_result_t best;
   logic         best_valid;

   sample_t      hist [`STEREO_NUM_DISP] = '{default: '0};   // model history, 0 is newest
   score_vec_t   exp_scores_q [$];
   disp_result_t exp_best_q [$];
   int           score_edge_q [$];
   int           best_edge_q [$];
   score_vec_t   held_scores = '0;
   disp_result_t held_best = '0;
   int           cycle_count = 0;
   logic [31:0]  lfsr_state = 32'hc42f;
   string        test_name = "init";

   tb_clock_gen u_clock_gen (
      .clk   (clk),
      .reset (reset)
   );

   stereo_corr_top u_dut (
      .clk          (clk),
      .reset        (reset),
      .sample_valid (sample_valid),
      .left_in      (left_in),
      .right_in     (right_in),
      .scores       (scores),
      .score_valid  (score_valid),
      .best         (best),
      .best_valid   (best_valid)
   );

   task automatic abort_run();
      $display("Test failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic report_problem(input string msg);
      $display("ERROR %s: %s", test_name, msg);
      abort_run();
   endtask

   task automatic check_scores(input string what, input score_vec_t exp, input score_vec_t act);
      if (exp !== act)
      begin
         $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_best(input string what, input disp_result_t exp,
                             input disp_result_t act);
      if (exp !== act)
      begin
         $display("[FAIL] %s %s: expected disp %0d score %0d, actual disp %0d score %0d",
                  test_name, what, exp.disp, exp.score, act.disp, act.score);
         abort_run();
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      if (exp !== act)
      begin
         $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_latency(input string what, input int exp, input int act);
      if (exp != act)
      begin
         $display("[FAIL] %s %s: expected %0d cycles, actual %0d cycles",
                  test_name, what, exp, act);
         abort_run();
      end
   endtask

   // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit taken
   function automatic int rand_bits(input int n);
      int   v;
      logic fb;
      v = 0;
      for (int i = 0; i < n; i++)
      begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         v = (v << 1) | int'(lfsr_state[0]);
      end
      return v;
   endfunction

   function automatic sample_t random_sample();
      return {pixel_t'(rand_bits(8)), pixel_t'(rand_bits(8))};
   endfunction

   function automatic sample_t ring_point(input int i);
      return {pixel_t'(ring_re[i % 10]), pixel_t'(ring_re[9 - i % 10])};
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(posedge clk);
         #1;
         sample_valid = 1'b0;
      end
   endtask

   // drives one strobe and queues what the model expects for it
   task automatic drive_strobe(input sample_t l, input sample_t r);
      score_vec_t   exp_s;
      disp_result_t exp_b;
      int           sc;
      int           top;
      @(posedge clk);
      #1;
      sample_valid = 1'b1;
      left_in = l;
      right_in = r;
      for (int d = `STEREO_NUM_DISP - 1; d > 0; d--)
         hist[d] = hist[d-1];
      hist[0] = l;
      top = 0;
      for (int d = 0; d < `STEREO_NUM_DISP; d++)
      begin
         sc = int'(hist[d].re) * int'(r.re) + int'(hist[d].im) * int'(r.im);
         exp_s[d] = score_t'(sc);
         if (sc > top)
            top = sc;
      end
      exp_b.disp = '0;
      for (int d = `STEREO_NUM_DISP - 1; d >= 0; d--)   // scanning down leaves the lowest index
         if (int'(exp_s[d]) == top)
            exp_b.disp = disp_t'(d);
      exp_b.score = score_t'(top);
      exp_scores_q.push_back(exp_s);
      exp_best_q.push_back(exp_b);
      score_edge_q.push_back(cycle_count + 1);   // captured at the next edge
      best_edge_q.push_back(cycle_count + 1);
   endtask

   task automatic drain_results();
      int n;
      n = 0;
      idle_cycles(1);
      while (exp_best_q.size() != 0 && n < 10)
      begin
         idle_cycles(1);
         n++;
      end
      if (exp_scores_q.size() != 0 || exp_best_q.size() != 0)
         report_problem("a valid pulse never arrived for an outstanding strobe");
   endtask

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   // outputs are sampled mid-cycle
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (score_valid)
         begin
            if (exp_scores_q.size() == 0)
               report_problem("score_valid pulsed with no strobe outstanding");
            check_latency("score latency", 3, cycle_count - score_edge_q.pop_front());
            check_scores("scores", exp_scores_q.pop_front(), scores);
            held_scores = scores;
         end
         else
            check_scores("held scores", held_scores, scores);
         if (best_valid)
         begin
            if (exp_best_q.size() == 0)
               report_problem("best_valid pulsed with no strobe outstanding");
            check_latency("best latency", 4, cycle_count - best_edge_q.pop_front());
            check_best("best", exp_best_q.pop_front(), best);
            held_best = best;
         end
         else
            check_best("held best", held_best, best);
      end
   end

   task automatic test_reset_state();
      test_name = "reset_state";
      idle_cycles(5);
      check_bit("score_valid", 1'b0, score_valid);
      check_bit("best_valid", 1'b0, best_valid);
      check_scores("scores", '0, scores);
      check_best("best", '0, best);
   endtask

   task automatic test_impulse();
      test_name = "impulse";
      drive_strobe({8'd9, 8'd4}, {8'd6, 8'd11});
      idle_cycles(6);
      for (int n = 0; n < 12; n++)
      begin
         drive_strobe('0, {8'd6, 8'd11});             // impulse walks one tap per strobe
         idle_cycles(6);
      end
      drain_results();
      check_best("all scores zero", '0, best);
   endtask

   task automatic test_known_shift();
      disp_result_t exp;
      test_name = "known_shift";
      for (int n = 0; n < 25; n++)
         drive_strobe(ring_point(n), ring_point(n + 5));   // matches the left sample 5 back
      drain_results();
      exp = {disp_t'(5), score_t'(4225)};
      check_best("shift of 5", exp, best);
   endtask

   task automatic test_ties();
      score_vec_t   full;
      disp_result_t exp;
      test_name = "ties";
      repeat (`STEREO_NUM_DISP) drive_strobe({8'd255, 8'd255}, {8'd255, 8'd255});
      drain_results();
      for (int d = 0; d < `STEREO_NUM_DISP; d++)
         full[d] = score_t'(130050);
      exp = {disp_t'(0), score_t'(130050)};
      check_scores("all 255 scores", full, scores);
      check_best("all 255 best", exp, best);
      // strobes 3 and 7 end up in taps 7 and 3
      for (int i = 0; i < `STEREO_NUM_DISP; i++)
         drive_strobe((i == 3 || i == 7) ? {8'd200, 8'd200} : {8'd10, 8'd10}, {8'd1, 8'd1});
      drain_results();
      exp = {disp_t'(3), score_t'(400)};
      check_best("tie of 3 and 7", exp, best);
   endtask

   task automatic test_gapped();
      test_name = "gapped";
      for (int n = 0; n < 30; n++)
      begin
         drive_strobe(random_sample(), random_sample());
         idle_cycles(rand_bits(3));
      end
      drain_results();
   endtask

   task automatic test_random_stream();
      test_name = "random_stream";
      repeat (200) drive_strobe(random_sample(), random_sample());
      drain_results();
   endtask

   initial
   begin
      sample_valid = 1'b0;
      left_in = '0;
      right_in = '0;
      wait (reset === 1'b0);
      test_reset_state();
      test_impulse();
      test_known_shift();
      test_ties();
      test_gapped();
      test_random_stream();
      $display("Test passed");
      $finish;
   end

   initial
   begin
      #(max_cycles * 10);
      $display("ERROR watchdog: run did not finish within %0d cycles", max_cycles);
      abort_run();
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
stereo_pkg.sv
corr_delay_line.sv
corr_cell.sv
corr_array.sv
disparity_select.sv
stereo_corr_top.sv
tb_clock_gen.sv
tb_stereo_corr.sv

//--- Makefile
obj_dir/Vtb_stereo_corr: verilog.f $(wildcard *.sv *.svh)
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_stereo_corr -f verilog.f

run: obj_dir/Vtb_stereo_corr
	obj_dir/Vtb_stereo_corr > sim.log 2>&1; cat sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
